// ==== tb.f ====
hdl/tcdm_pkg.sv
hdl/amo_alu.sv
hdl/amo_ctrl.sv
hdl/resp_buffer.sv
hdl/tcdm_adapter.sv
verif/sram_model.sv
verif/tcdm_adapter_tb.sv

// ==== Makefile ====
OBJ_DIR := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timescale 1ns/1ps -f tb.f --top-module tcdm_adapter_tb \
		--Mdir $(OBJ_DIR) -o tcdm_adapter_sim
	./$(OBJ_DIR)/tcdm_adapter_sim | tee /dev/stderr | grep -x "TESTS PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tcdm_adapter_tb.sv ====
// ----------------------------------------------------------
// Random testbench for the TCDM bank adapter
// Addresses stay within the first 64 words of the bank
// One request is offered at a time and held until accepted
// ----------------------------------------------------------
`default_nettype none

module tcdm_adapter_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumWords  = 64;
  localparam int unsigned NumTxn    = 2000;
  localparam int unsigned MaxCycles = NumTxn * 40;
  localparam int unsigned IdxMsb    = $clog2(NumWords) + 1;

  logic clk;
  logic rst_n;
  // Request side
  logic        req_valid;
  logic        req_ready;
  logic [31:0] req_addr;
  logic [3:0]  req_amo;
  logic        req_write;
  logic [31:0] req_wdata;
  logic [7:0]  req_meta;
  logic [3:0]  req_be;
  // Response side
  logic        rsp_valid;
  logic        rsp_ready;
  logic [31:0] rsp_rdata;
  logic [7:0]  rsp_meta;
  // SRAM port
  logic        sram_req;
  logic [31:0] sram_addr;
  logic        sram_write;
  logic [31:0] sram_wdata;
  logic [3:0]  sram_be;
  logic [31:0] sram_rdata;

  // Reference memory and outstanding responses
  logic [31:0] model_mem [NumWords];
  logic [31:0] exp_data_q [$];
  logic [7:0]  exp_meta_q [$];
  string       exp_name_q [$];

  int unsigned errors;
  int unsigned accepted;
  int unsigned responses;
  logic        req_pending;
  // Previous cycle, for the hold and write-back checks
  logic        prev_hold;
  logic [31:0] prev_rdata;
  logic [7:0]  prev_meta;
  logic        prev_amo_acc;
  logic [31:0] rng_state = 32'd8;

  tcdm_adapter dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .in_valid_i   (req_valid),
    .in_ready_o   (req_ready),
    .in_address_i (req_addr),
    .in_amo_i     (req_amo),
    .in_write_i   (req_write),
    .in_wdata_i   (req_wdata),
    .in_meta_i    (req_meta),
    .in_be_i      (req_be),
    .in_valid_o   (rsp_valid),
    .in_ready_i   (rsp_ready),
    .in_rdata_o   (rsp_rdata),
    .in_meta_o    (rsp_meta),
    .out_req_o    (sram_req),
    .out_add_o    (sram_addr),
    .out_write_o  (sram_write),
    .out_wdata_o  (sram_wdata),
    .out_be_o     (sram_be),
    .out_rdata_i  (sram_rdata)
  );

  sram_model #(.NumWords(NumWords)) sram (
    .clk_i   (clk),
    .req_i   (sram_req),
    .addr_i  (sram_addr),
    .write_i (sram_write),
    .wdata_i (sram_wdata),
    .be_i    (sram_be),
    .rdata_o (sram_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Model helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic is_amo_code(input logic [3:0] op);
    return (op >= 4'd1) && (op <= 4'd9);
  endfunction

  // Value an AMO leaves in memory
  function automatic logic [31:0] apply_amo(input logic [3:0] op, input logic [31:0] old,
                                            input logic [31:0] opnd);
    case (op)
      tcdm_pkg::Swap: return opnd;
      tcdm_pkg::Add:  return old + opnd;
      tcdm_pkg::And:  return old & opnd;
      tcdm_pkg::Or:   return old | opnd;
      tcdm_pkg::Xor:  return old ^ opnd;
      tcdm_pkg::Max:  return ($signed(old) > $signed(opnd)) ? old : opnd;
      tcdm_pkg::Maxu: return (old > opnd) ? old : opnd;
      tcdm_pkg::Min:  return ($signed(old) < $signed(opnd)) ? old : opnd;
      tcdm_pkg::Minu: return (old < opnd) ? old : opnd;
      default:        return old;
    endcase
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic string op_name(input logic [3:0] op);
    case (op)
      tcdm_pkg::Swap: return "amo_swap";
      tcdm_pkg::Add:  return "amo_add";
      tcdm_pkg::And:  return "amo_and";
      tcdm_pkg::Or:   return "amo_or";
      tcdm_pkg::Xor:  return "amo_xor";
      tcdm_pkg::Max:  return "amo_max";
      tcdm_pkg::Maxu: return "amo_maxu";
      tcdm_pkg::Min:  return "amo_min";
      tcdm_pkg::Minu: return "amo_minu";
      default:        return "load";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("ERR %s expected %08h actual %08h at %0t", name, expected, actual, $time);
    end
  endtask

  // ----------------------------------------------------------
  // Per-cycle stimulus and checking
  // ----------------------------------------------------------
  // Rising edge, new inputs for the coming cycle
  task automatic drive_cycle();
    logic [31:0] rnd;
    logic [31:0] word;
    logic [3:0]  sel;
    rsp_ready <= (next_random() % 4) != 0;
    if (!req_pending) begin
      if (accepted < NumTxn && (next_random() % 4) != 0) begin
        sel  = 4'(next_random() % 16);
        word = next_random() % NumWords;
        rnd  = next_random();
        req_valid <= 1'b1;
        req_addr  <= word << 2;
        req_wdata <= next_random();
        req_be    <= rnd[3:0];
        req_meta  <= rnd[15:8];
        if (sel < 4'd3) begin
          req_amo   <= 4'd0;
          req_write <= 1'b1;
        end else if (sel < 4'd6) begin
          req_amo   <= 4'd0;
          req_write <= 1'b0;
        end else if (sel < 4'd15) begin
          // Write flag is random, an AMO ignores it
          req_amo   <= sel - 4'd5;
          req_write <= rnd[16];
        end else begin
          // Reserved codes act as plain accesses
          req_amo   <= 4'd10 + (rnd[23:20] % 4'd6);
          req_write <= rnd[16];
        end
        req_pending = 1'b1;
      end else begin
        req_valid <= 1'b0;
      end
    end
  endtask

  // Falling edge, all outputs settled
  task automatic observe_cycle();
    int unsigned idx;
    logic [31:0] old;
    logic [31:0] exp_data;
    logic [7:0]  exp_meta;
    string       exp_name;
    if (prev_hold) begin
      check_value("held_valid", 32'd1, 32'(rsp_valid));
      check_value("held_rdata", prev_rdata, rsp_rdata);
      check_value("held_meta", 32'(prev_meta), 32'(rsp_meta));
    end
    if (rsp_valid && !rsp_ready) begin
      check_value("hold_blocks_request", 32'd0, 32'(req_ready));
    end
    if (prev_amo_acc) begin
      check_value("amo_writeback_ready", 32'd0, 32'(req_ready));
    end
    // Response taken at the coming edge
    if (rsp_valid && rsp_ready) begin
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("Response seen with no load or AMO outstanding at %0t", $time);
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_meta = exp_meta_q.pop_front();
        exp_name = exp_name_q.pop_front();
        check_value(exp_name, exp_data, rsp_rdata);
        check_value({exp_name, "_meta"}, 32'(exp_meta), 32'(rsp_meta));
        responses++;
      end
    end
    prev_hold    = rsp_valid && !rsp_ready;
    prev_rdata   = rsp_rdata;
    prev_meta    = rsp_meta;
    prev_amo_acc = 1'b0;
    // Request accepted at the coming edge
    if (req_valid && req_ready) begin
      idx = 32'(req_addr[IdxMsb:2]);
      old = model_mem[idx];
      if (is_amo_code(req_amo)) begin
        exp_data_q.push_back(old);
        exp_meta_q.push_back(req_meta);
        exp_name_q.push_back(op_name(req_amo));
        model_mem[idx] = apply_amo(req_amo, old, req_wdata);
        prev_amo_acc   = 1'b1;
      end else if (req_write) begin
        model_mem[idx] = merge_bytes(old, req_wdata, req_be);
      end else begin
        exp_data_q.push_back(old);
        exp_meta_q.push_back(req_meta);
        exp_name_q.push_back("load");
      end
      accepted++;
      req_pending = 1'b0;
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    errors       = 0;
    accepted     = 0;
    responses    = 0;
    req_pending  = 1'b0;
    prev_hold    = 1'b0;
    prev_rdata   = '0;
    prev_meta    = '0;
    prev_amo_acc = 1'b0;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_addr     = '0;
    req_amo      = '0;
    req_write    = 1'b0;
    req_wdata    = '0;
    req_meta     = '0;
    req_be       = '0;
    rsp_ready    = 1'b0;
    // Same fill as the SRAM starts with
    for (int i = 0; i < NumWords; i++) begin
      model_mem[i] = (32'(i) * 32'h0101_0101) ^ 32'hC3A5_0F96;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("reset_resp_valid", 32'd0, 32'(rsp_valid));
    check_value("reset_sram_req", 32'd0, 32'(sram_req));
    check_value("reset_req_ready", 32'd1, 32'(req_ready));
    while (accepted < NumTxn || exp_data_q.size() != 0) begin
      @(posedge clk);
      drive_cycle();
      @(negedge clk);
      observe_cycle();
    end
    $display("Run complete: %0d accepted, %0d responses checked, %0d errors",
             accepted, responses, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Hang guard, 40 cycles per transaction after reset
  initial begin
    repeat (MaxCycles + 16) @(posedge clk);
    $display("Watchdog expired, the DUT stopped accepting requests or returning responses");
    $display("Run aborted: %0d accepted, %0d responses checked, %0d errors",
             accepted, responses, errors);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/sram_model.sv ====
// ----------------------------------------------------------
// Behavioral single-port SRAM for the adapter testbench
// Read data appears one cycle after the request and holds
// Writes leave the read port untouched
// Starts with a fill pattern taken from the word index
// ----------------------------------------------------------
`default_nettype none

module sram_model #(
  parameter int unsigned NumWords = 64
) (
  input  logic            clk_i,
  input  logic            req_i,
  input  tcdm_pkg::addr_t addr_i,
  input  logic            write_i,
  input  tcdm_pkg::data_t wdata_i,
  input  tcdm_pkg::be_t   be_i,
  output tcdm_pkg::data_t rdata_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned IdxWidth = $clog2(NumWords);

  tcdm_pkg::data_t     mem [NumWords];
  logic [IdxWidth-1:0] idx;

  // Byte address, word aligned, upper bits ignored
  assign idx = addr_i[IdxWidth+1:2];

  initial begin
    for (int i = 0; i < NumWords; i++) begin
      mem[i] <= (32'(i) * 32'h0101_0101) ^ 32'hC3A5_0F96;
    end
    rdata_o <= '0;
  end

  always @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        // Only enabled bytes change
        for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
          if (be_i[b]) begin
            mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tcdm_adapter.sv ====
// ----------------------------------------------------------
// Adapter in front of one single-port SRAM bank
// Needs exclusive access to the bank, no grant is expected
// Read data must appear one cycle after the request
// ----------------------------------------------------------
`default_nettype none

module tcdm_adapter (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Request stream
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  tcdm_pkg::addr_t in_address_i,
  input  logic [3:0]      in_amo_i,
  input  logic            in_write_i,
  input  tcdm_pkg::data_t in_wdata_i,
  input  tcdm_pkg::meta_t in_meta_i,
  input  tcdm_pkg::be_t   in_be_i,
  // Response stream
  output logic            in_valid_o,
  input  logic            in_ready_i,
  output tcdm_pkg::data_t in_rdata_o,
  output tcdm_pkg::meta_t in_meta_o,
  // SRAM port
  output logic            out_req_o,
  output tcdm_pkg::addr_t out_add_o,
  output logic            out_write_o,
  output tcdm_pkg::data_t out_wdata_o,
  output tcdm_pkg::be_t   out_be_o,
  input  tcdm_pkg::data_t out_rdata_i
);

  logic              read_issued;
  logic              resp_hold;
  tcdm_pkg::amo_op_e amo_op;
  tcdm_pkg::data_t   amo_operand;
  tcdm_pkg::data_t   amo_result;

  // ----------------------------------------------------------
  // Request path and AMO sequencing
  // ----------------------------------------------------------
  amo_ctrl i_amo_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .in_address_i  (in_address_i),
    .in_amo_i      (in_amo_i),
    .in_write_i    (in_write_i),
    .in_wdata_i    (in_wdata_i),
    .in_be_i       (in_be_i),
    .resp_hold_i   (resp_hold),
    .amo_result_i  (amo_result),
    .amo_op_o      (amo_op),
    .amo_operand_o (amo_operand),
    .read_issued_o (read_issued),
    .out_req_o     (out_req_o),
    .out_add_o     (out_add_o),
    .out_write_o   (out_write_o),
    .out_wdata_o   (out_wdata_o),
    .out_be_o      (out_be_o)
  );

  // Old word comes straight from the SRAM
  amo_alu i_amo_alu (
    .op_i       (amo_op),
    .mem_data_i (out_rdata_i),
    .operand_i  (amo_operand),
    .result_o   (amo_result)
  );

  // Response pairing and back-pressure
  resp_buffer i_resp_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .read_issued_i (read_issued),
    .meta_i        (in_meta_i),
    .rdata_i       (out_rdata_i),
    .resp_valid_o  (in_valid_o),
    .resp_ready_i  (in_ready_i),
    .resp_rdata_o  (in_rdata_o),
    .resp_meta_o   (in_meta_o),
    .resp_hold_o   (resp_hold)
  );

endmodule

`default_nettype wire

// ==== hdl/resp_buffer.sv ====
// ----------------------------------------------------------
// One-entry response slot for the TCDM bank adapter
// Read data is expected one cycle after read_issued_i
// Fall-through, so a response is valid when the data arrives
// A new read may only be issued when no response is held
// ----------------------------------------------------------
`default_nettype none

module resp_buffer (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Read request went to the SRAM this cycle
  input  logic            read_issued_i,
  input  tcdm_pkg::meta_t meta_i,
  // SRAM read data
  input  tcdm_pkg::data_t rdata_i,
  // Response stream
  output logic            resp_valid_o,
  input  logic            resp_ready_i,
  output tcdm_pkg::data_t resp_rdata_o,
  output tcdm_pkg::meta_t resp_meta_o,
  output logic            resp_hold_o
);

  // Metadata slot
  logic            meta_valid_q;
  tcdm_pkg::meta_t meta_q;
  // SRAM data arrives this cycle
  logic            capture_q;
  // Data slot
  logic            data_valid_q;
  tcdm_pkg::data_t data_q;
  logic            data_present;
  logic            resp_taken;

  // ----------------------------------------------------------
  // Output side
  // ----------------------------------------------------------
  // Data counts as present straight from the SRAM
  assign data_present = data_valid_q || capture_q;
  assign resp_valid_o = meta_valid_q && data_present;
  assign resp_rdata_o = data_valid_q ? data_q : rdata_i;
  assign resp_meta_o  = meta_q;
  assign resp_taken   = resp_valid_o && resp_ready_i;
  // Stalls the request side
  assign resp_hold_o  = resp_valid_o && !resp_ready_i;

  // ----------------------------------------------------------
  // Slot state
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_valid_q <= 1'b0;
      capture_q    <= 1'b0;
      data_valid_q <= 1'b0;
    end else begin
      capture_q <= read_issued_i;
      // New issue wins over the free of the previous entry
      if (read_issued_i) begin
        meta_valid_q <= 1'b1;
      end else if (resp_taken) begin
        meta_valid_q <= 1'b0;
      end
      // Keep the SRAM word only when it was not taken at once
      if (resp_taken) begin
        data_valid_q <= 1'b0;
      end else if (capture_q) begin
        data_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_issued_i) begin
      meta_q <= meta_i;
    end
    // SRAM output changes after this cycle
    if (capture_q && !resp_taken) begin
      data_q <= rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/amo_ctrl.sv ====
// ----------------------------------------------------------
// Request path of the TCDM bank adapter
// Requests pass straight to the SRAM in Idle
// An AMO reads in its accept cycle and writes back one cycle later
// No new request is taken while a response is held
// ----------------------------------------------------------
`default_nettype none

module amo_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Request stream
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  tcdm_pkg::addr_t   in_address_i,
  input  logic [3:0]        in_amo_i,
  input  logic              in_write_i,
  input  tcdm_pkg::data_t   in_wdata_i,
  input  tcdm_pkg::be_t     in_be_i,
  // Pending response not yet taken
  input  logic              resp_hold_i,
  // ALU
  input  tcdm_pkg::data_t   amo_result_i,
  output tcdm_pkg::amo_op_e amo_op_o,
  output tcdm_pkg::data_t   amo_operand_o,
  // One pulse per accepted load or AMO
  output logic              read_issued_o,
  // SRAM port
  output logic              out_req_o,
  output tcdm_pkg::addr_t   out_add_o,
  output logic              out_write_o,
  output tcdm_pkg::data_t   out_wdata_o,
  output tcdm_pkg::be_t     out_be_o
);

  typedef enum logic {
    Idle,
    DoAmo
  } state_e;

  state_e            state_q, state_d;
  tcdm_pkg::amo_op_e req_op;
  logic              is_amo;
  logic              req_accepted;
  // Stored AMO request
  tcdm_pkg::amo_op_e amo_op_q;
  tcdm_pkg::addr_t   addr_q;
  tcdm_pkg::data_t   operand_q;

  assign req_op = tcdm_pkg::amo_op_e'(in_amo_i);
  // Codes outside Swap..Minu are plain accesses
  assign is_amo = req_op inside {tcdm_pkg::Swap, tcdm_pkg::Add, tcdm_pkg::And,
                                 tcdm_pkg::Or, tcdm_pkg::Xor, tcdm_pkg::Max,
                                 tcdm_pkg::Maxu, tcdm_pkg::Min, tcdm_pkg::Minu};

  // Blocked during write-back and while a response waits
  assign in_ready_o    = (state_q == Idle) && !resp_hold_i;
  assign req_accepted  = in_valid_i && in_ready_o;
  // AMOs always return the old word
  assign read_issued_o = req_accepted && (is_amo || !in_write_i);

  assign amo_op_o      = amo_op_q;
  assign amo_operand_o = operand_q;

  // ----------------------------------------------------------
  // FSM and SRAM port steering
  // ----------------------------------------------------------
  always_comb begin
    state_d     = state_q;
    // Feed-through of the request
    out_req_o   = req_accepted;
    out_add_o   = in_address_i;
    out_write_o = in_write_i && !is_amo;
    out_wdata_o = in_wdata_i;
    out_be_o    = in_be_i;
    case (state_q)
      Idle: begin
        if (req_accepted && is_amo) begin
          state_d = DoAmo;
        end
      end
      DoAmo: begin
        // Old word is on out_rdata now, commit the result
        out_req_o   = 1'b1;
        out_add_o   = addr_q;
        out_write_o = 1'b1;
        out_wdata_o = amo_result_i;
        out_be_o    = tcdm_pkg::FullBe;
        state_d     = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Operands of the AMO, loaded on accept
  always_ff @(posedge clk_i) begin
    if (req_accepted && is_amo) begin
      amo_op_q  <= req_op;
      addr_q    <= in_address_i;
      operand_q <= in_wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/amo_alu.sv ====
// ----------------------------------------------------------
// Write-back value of an atomic memory operation
// Purely combinational, valid while the old word is on the bus
// Unknown opcodes give a zero result
// ----------------------------------------------------------
`default_nettype none

module amo_alu (
  input  tcdm_pkg::amo_op_e op_i,
  input  tcdm_pkg::data_t   mem_data_i,
  input  tcdm_pkg::data_t   operand_i,
  output tcdm_pkg::data_t   result_o
);

  // Shared adder, one bit wider than the data word
  logic [tcdm_pkg::DataWidth:0] adder_a;
  logic [tcdm_pkg::DataWidth:0] adder_b;
  logic                         adder_cin;
  logic [tcdm_pkg::DataWidth:0] adder_sum;
  // Set when the old word is below the operand
  logic                         less;

  // ----------------------------------------------------------
  // Adder operand selection
  // ----------------------------------------------------------
  always_comb begin
    // Plain unsigned add by default
    adder_a   = {1'b0, mem_data_i};
    adder_b   = {1'b0, operand_i};
    adder_cin = 1'b0;
    case (op_i)
      tcdm_pkg::Max, tcdm_pkg::Min: begin
        // Sign extend both, then a - b as a + ~b + 1
        adder_a   = {mem_data_i[tcdm_pkg::DataWidth-1], mem_data_i};
        adder_b   = ~{operand_i[tcdm_pkg::DataWidth-1], operand_i};
        adder_cin = 1'b1;
      end
      tcdm_pkg::Maxu, tcdm_pkg::Minu: begin
        // Zero extend, top bit becomes the borrow
        adder_b   = ~{1'b0, operand_i};
        adder_cin = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign adder_sum = adder_a + adder_b + {{tcdm_pkg::DataWidth{1'b0}}, adder_cin};
  // Sign of the 33-bit difference
  assign less      = adder_sum[tcdm_pkg::DataWidth];

  // ----------------------------------------------------------
  // Result selection
  // ----------------------------------------------------------
  always_comb begin
    case (op_i)
      tcdm_pkg::Swap: result_o = operand_i;
      // Wrapping add, carry dropped
      tcdm_pkg::Add:  result_o = adder_sum[tcdm_pkg::DataWidth-1:0];
      tcdm_pkg::And:  result_o = mem_data_i & operand_i;
      tcdm_pkg::Or:   result_o = mem_data_i | operand_i;
      tcdm_pkg::Xor:  result_o = mem_data_i ^ operand_i;
      // Larger of the two
      tcdm_pkg::Max, tcdm_pkg::Maxu: result_o = less ? operand_i : mem_data_i;
      // Smaller of the two
      tcdm_pkg::Min, tcdm_pkg::Minu: result_o = less ? mem_data_i : operand_i;
      default:        result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/tcdm_pkg.sv ====
// ----------------------------------------------------------
// Shared widths and types of the TCDM bank adapter
// Data path fixed at 32 bits, byte enables one per byte
// AMO codes 10 to 15 carry no operation and act as AmoNone
// ----------------------------------------------------------
`default_nettype none

package tcdm_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  // Byte address of the request
  localparam int unsigned AddrWidth = 32;
  // One memory word
  localparam int unsigned DataWidth = 32;
  // One enable per byte
  localparam int unsigned BeWidth   = DataWidth / 8;
  // Opaque requester tag, returned with the read data
  localparam int unsigned MetaWidth = 8;

  // ----------------------------------------------------------
  // Data types
  // ----------------------------------------------------------
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;
  typedef logic [MetaWidth-1:0] meta_t;

  // All bytes written, used by the AMO write-back
  localparam be_t FullBe = '1;

  // Atomic memory operation codes
  typedef enum logic [3:0] {
    AmoNone = 4'd0,
    Swap    = 4'd1,
    Add     = 4'd2,
    And     = 4'd3,
    Or      = 4'd4,
    Xor     = 4'd5,
    Max     = 4'd6,
    Maxu    = 4'd7,
    Min     = 4'd8,
    Minu    = 4'd9
  } amo_op_e;

endpackage

`default_nettype wire
